// ==== cache_ram.sv ====
`default_nettype none

module cache_ram #(
    parameter int unsigned INDEX_W = 7,
    parameter type         entry_t = logic [31:0]
) (
    input  logic               clk,
    input  logic [INDEX_W-1:0] raddr_i,
    input  logic [INDEX_W-1:0] waddr_i,
    input  logic               we_i,
    input  entry_t             wdata_i,
    output entry_t             rdata_o
);

    localparam int unsigned SETS = 1 << INDEX_W;

    entry_t mem [SETS];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
        if (we_i && (waddr_i == raddr_i)) begin
            rdata_o <= wdata_i;         // collision returns the new entry
        end else begin
            rdata_o <= mem[raddr_i];
        end
    end

endmodule

`default_nettype wire

// ==== dcache.sv ====
`default_nettype none

module dcache
    import dcache_pkg::*;
#(
    parameter int unsigned INDEX_W = 7
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        req_valid_i,
    input  cpu_req_t    req_i,
    output logic        addr_ok_o,
    output logic        data_ok_o,
    output word_t       rdata_o,
    output logic        rd_req_o,
    output logic [31:0] rd_addr_o,
    input  logic        ret_valid_i,
    input  line_t       ret_line_i,
    output logic        wr_req_o,
    output logic [31:0] wr_addr_o,
    output line_t       wr_line_o,
    input  logic        wr_done_i,
    output logic        uc_ren_o,
    output logic        uc_wen_o,
    output logic [31:0] uc_addr_o,
    output word_t       uc_wdata_o,
    output logic [3:0]  uc_strb_o,
    input  word_t       uc_rdata_i,
    input  logic        uc_rvalid_i,
    input  logic        uc_bvalid_i
);

    cpu_req_t              req_q;
    logic [INDEX_W-1:0]    read_index;
    logic [INDEX_W-1:0]    set_index;
    logic [WORD_SEL_W-1:0] word_sel;
    logic [1:0]            data_we;
    logic [1:0]            tag_we;
    logic [1:0]            way_match;
    logic [1:0]            valid;
    logic [1:0]            rdata_sel;
    logic                  merge_sel;
    logic                  wb_load;
    logic                  wb_busy;
    logic                  touch;
    logic                  touch_way;
    logic                  fill;
    logic                  fill_way;
    logic                  set_dirty;
    logic                  clean;
    logic                  victim_way;
    logic                  victim_dirty;
    line_t [1:0]           way_line;
    tagv_t [1:0]           tag_rd;
    tagv_t                 tag_wdata;
    line_t                 hit_line;
    line_t                 hit_merged;
    line_t                 refill_merged;
    line_t                 bank_wdata;

    assign set_index = req_q.addr[OFFSET_W +: INDEX_W];
    assign word_sel  = req_q.addr[OFFSET_W-1:2];
    assign tag_wdata = '{valid: 1'b1, num: req_q.addr[31:OFFSET_W]};
    assign hit_line  = way_match[1] ? way_line[1] : way_line[0];
    assign bank_wdata = merge_sel ? refill_merged : hit_merged;

    for (genvar w = 0; w < 2; w++) begin : g_way
        for (genvar b = 0; b < WORDS_PER_LINE; b++) begin : g_bank
            cache_ram #(.INDEX_W(INDEX_W), .entry_t(word_t)) u_bank (
                .clk     (clk),
                .raddr_i (read_index),
                .waddr_i (set_index),
                .we_i    (data_we[w]),
                .wdata_i (bank_wdata[b]),
                .rdata_o (way_line[w][b])
            );
        end
        cache_ram #(.INDEX_W(INDEX_W), .entry_t(tagv_t)) u_tag (
            .clk     (clk),
            .raddr_i (read_index),
            .waddr_i (set_index),
            .we_i    (tag_we[w]),
            .wdata_i (tag_wdata),
            .rdata_o (tag_rd[w])
        );
        assign way_match[w] = valid[w] && tag_rd[w].valid
                              && (tag_rd[w].num == req_q.addr[31:OFFSET_W]);
    end

    dcache_lru_dirty #(.INDEX_W(INDEX_W)) u_lru_dirty (
        .clk            (clk),
        .reset          (reset),
        .index_i        (set_index),
        .touch_i        (touch),
        .touch_way_i    (touch_way),
        .fill_i         (fill),
        .fill_way_i     (fill_way),
        .set_dirty_i    (set_dirty),
        .clean_i        (clean),
        .valid_o        (valid),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty)
    );

    dcache_line_merge u_hit_merge (
        .base_line_i (hit_line),
        .word_sel_i  (word_sel),
        .wdata_i     (req_q.wdata),
        .wstrb_i     (req_q.wstrb),
        .merge_i     (req_q.op),
        .line_o      (hit_merged)
    );

    dcache_line_merge u_refill_merge (
        .base_line_i (ret_line_i),
        .word_sel_i  (word_sel),
        .wdata_i     (req_q.wdata),
        .wstrb_i     (req_q.wstrb),
        .merge_i     (req_q.op),
        .line_o      (refill_merged)
    );

    dcache_writeback_buf #(.INDEX_W(INDEX_W)) u_wb_buf (
        .clk           (clk),
        .reset         (reset),
        .load_i        (wb_load),
        .victim_line_i (way_line[victim_way]),
        .victim_num_i  (tag_rd[victim_way].num),
        .wr_done_i     (wr_done_i),
        .wr_req_o      (wr_req_o),
        .wr_addr_o     (wr_addr_o),
        .wr_line_o     (wr_line_o),
        .busy_o        (wb_busy)
    );

    dcache_ctrl #(.INDEX_W(INDEX_W)) u_ctrl (
        .clk            (clk),
        .reset          (reset),
        .req_valid_i    (req_valid_i),
        .req_i          (req_i),
        .addr_ok_o      (addr_ok_o),
        .data_ok_o      (data_ok_o),
        .way_match_i    (way_match),
        .victim_way_i   (victim_way),
        .victim_dirty_i (victim_dirty),
        .ret_valid_i    (ret_valid_i),
        .wb_busy_i      (wb_busy),
        .uc_rvalid_i    (uc_rvalid_i),
        .uc_bvalid_i    (uc_bvalid_i),
        .req_o          (req_q),
        .read_index_o   (read_index),
        .data_we_o      (data_we),
        .tag_we_o       (tag_we),
        .merge_sel_o    (merge_sel),
        .wb_load_o      (wb_load),
        .touch_o        (touch),
        .touch_way_o    (touch_way),
        .fill_o         (fill),
        .fill_way_o     (fill_way),
        .set_dirty_o    (set_dirty),
        .clean_o        (clean),
        .rd_req_o       (rd_req_o),
        .uc_ren_o       (uc_ren_o),
        .uc_wen_o       (uc_wen_o),
        .rdata_sel_o    (rdata_sel)
    );

    // uncached data or the selected way's word
    assign rdata_o = rdata_sel[1] ? uc_rdata_i : way_line[rdata_sel[0]][word_sel];

    assign rd_addr_o  = {req_q.addr[31:OFFSET_W], {OFFSET_W{1'b0}}};
    assign uc_addr_o  = req_q.addr;
    assign uc_wdata_o = req_q.wdata;
    assign uc_strb_o  = req_q.wstrb;

endmodule

`default_nettype wire

// ==== dcache_ctrl.sv ====
`default_nettype none

module dcache_ctrl
    import dcache_pkg::*;
#(
    parameter int unsigned INDEX_W = 7
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               req_valid_i,
    input  cpu_req_t           req_i,
    output logic               addr_ok_o,
    output logic               data_ok_o,
    input  logic [1:0]         way_match_i,
    input  logic               victim_way_i,
    input  logic               victim_dirty_i,
    input  logic               ret_valid_i,
    input  logic               wb_busy_i,
    input  logic               uc_rvalid_i,
    input  logic               uc_bvalid_i,
    output cpu_req_t           req_o,
    output logic [INDEX_W-1:0] read_index_o,
    output logic [1:0]         data_we_o,
    output logic [1:0]         tag_we_o,
    output logic               merge_sel_o,
    output logic               wb_load_o,
    output logic               touch_o,
    output logic               touch_way_o,
    output logic               fill_o,
    output logic               fill_way_o,
    output logic               set_dirty_o,
    output logic               clean_o,
    output logic               rd_req_o,
    output logic               uc_ren_o,
    output logic               uc_wen_o,
    output logic [1:0]         rdata_sel_o
);

    typedef enum logic [2:0] {
        S_IDLE,                         // also the lookup cycle
        S_WB,
        S_REFILL,
        S_RET,
        S_UC
    } state_t;

    state_t   state_q;
    state_t   state_d;
    cpu_req_t req_q;
    logic     req_v_q;                  // lookup pending, only ever set in idle
    logic     way_q;                    // way being refilled
    logic     cached;
    logic     hit;
    logic     hit_way;

    assign cached  = req_v_q && !req_q.uncached;
    assign hit     = cached && (|way_match_i);
    assign hit_way = way_match_i[1];

    // a read hit frees the slot in its own lookup cycle
    assign addr_ok_o = req_valid_i && (state_q == S_IDLE)
                       && (!req_v_q || (hit && req_q.op == OP_READ));

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= S_IDLE;
            req_v_q <= 1'b0;
            way_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            req_v_q <= addr_ok_o;
            if (cached && !hit) begin
                way_q <= victim_way_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (addr_ok_o) begin
            req_q <= req_i;
        end
    end

    always_comb begin
        state_d     = state_q;
        data_ok_o   = 1'b0;
        data_we_o   = 2'b00;
        tag_we_o    = 2'b00;
        wb_load_o   = 1'b0;
        touch_o     = 1'b0;
        fill_o      = 1'b0;
        set_dirty_o = 1'b0;
        clean_o     = 1'b0;
        rdata_sel_o = {1'b0, hit_way};
        case (state_q)
            S_IDLE: begin
                if (req_v_q && req_q.uncached) begin
                    state_d = S_UC;
                end else if (hit) begin
                    touch_o = 1'b1;
                    if (req_q.op == OP_WRITE) begin
                        data_we_o[hit_way] = 1'b1;
                        set_dirty_o        = 1'b1;
                    end else begin
                        data_ok_o = 1'b1;
                    end
                end else if (cached) begin
                    wb_load_o = victim_dirty_i;
                    state_d   = victim_dirty_i ? S_WB : S_REFILL;
                end
            end
            S_WB: begin
                if (!wb_busy_i) begin
                    state_d = S_REFILL;
                end
            end
            S_REFILL: begin
                if (ret_valid_i) begin
                    data_we_o[way_q] = 1'b1;
                    tag_we_o[way_q]  = 1'b1;
                    fill_o           = 1'b1;
                    set_dirty_o      = (req_q.op == OP_WRITE);
                    clean_o          = (req_q.op == OP_READ);
                    state_d          = S_RET;
                end
            end
            S_RET: begin
                data_ok_o   = (req_q.op == OP_READ);
                rdata_sel_o = {1'b0, way_q};
                state_d     = S_IDLE;
            end
            S_UC: begin
                rdata_sel_o = 2'b10;
                if (req_q.op == OP_READ && uc_rvalid_i) begin
                    data_ok_o = 1'b1;
                    state_d   = S_IDLE;
                end else if (req_q.op == OP_WRITE && uc_bvalid_i) begin
                    state_d = S_IDLE;
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    assign read_index_o = (state_q == S_IDLE) ? req_i.addr[OFFSET_W +: INDEX_W]
                                              : req_q.addr[OFFSET_W +: INDEX_W];

    assign req_o       = req_q;
    assign merge_sel_o = (state_q == S_REFILL);
    assign touch_way_o = hit_way;
    assign fill_way_o  = way_q;
    assign rd_req_o    = (state_q == S_REFILL);
    assign uc_ren_o    = (state_q == S_UC) && (req_q.op == OP_READ);
    assign uc_wen_o    = (state_q == S_UC) && (req_q.op == OP_WRITE);

endmodule

`default_nettype wire

// ==== dcache_line_merge.sv ====
`default_nettype none

module dcache_line_merge
    import dcache_pkg::*;
(
    input  line_t                 base_line_i,
    input  logic [WORD_SEL_W-1:0] word_sel_i,
    input  word_t                 wdata_i,
    input  logic [3:0]            wstrb_i,
    input  logic                  merge_i,
    output line_t                 line_o
);

    word_t old_word;
    word_t new_word;

    assign old_word = base_line_i[word_sel_i];

    // byte lanes under the strobes
    always_comb begin
        new_word = old_word;
        for (int b = 0; b < 4; b++) begin
            if (wstrb_i[b]) begin
                new_word[8*b +: 8] = wdata_i[8*b +: 8];
            end
        end
    end

    always_comb begin
        line_o = base_line_i;
        if (merge_i) begin
            line_o[word_sel_i] = new_word;
        end
    end

endmodule

`default_nettype wire

// ==== dcache_lru_dirty.sv ====
`default_nettype none

module dcache_lru_dirty #(
    parameter int unsigned INDEX_W = 7
) (
    input  logic               clk,
    input  logic               reset,
    input  logic [INDEX_W-1:0] index_i,
    input  logic               touch_i,
    input  logic               touch_way_i,
    input  logic               fill_i,
    input  logic               fill_way_i,
    input  logic               set_dirty_i,
    input  logic               clean_i,
    output logic [1:0]         valid_o,
    output logic               victim_way_o,
    output logic               victim_dirty_o
);

    localparam int unsigned SETS = 1 << INDEX_W;

    logic [SETS-1:0][1:0] valid_q;
    logic [SETS-1:0][1:0] dirty_q;
    logic [SETS-1:0]      lru_q;        // way to replace next
    logic                 mark_way;

    assign mark_way = fill_i ? fill_way_i : touch_way_i;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            if (fill_i) begin
                valid_q[index_i][fill_way_i] <= 1'b1;
                lru_q[index_i]               <= ~fill_way_i;
            end else if (touch_i) begin
                lru_q[index_i] <= ~touch_way_i;
            end
            if (set_dirty_i) begin
                dirty_q[index_i][mark_way] <= 1'b1;
            end else if (clean_i) begin
                dirty_q[index_i][mark_way] <= 1'b0;
            end
        end
    end

    assign valid_o = valid_q[index_i];

    always_comb begin
        if (!valid_q[index_i][0]) begin
            victim_way_o = 1'b0;
        end else if (!valid_q[index_i][1]) begin
            victim_way_o = 1'b1;
        end else begin
            victim_way_o = lru_q[index_i];
        end
    end

    assign victim_dirty_o = valid_q[index_i][victim_way_o] && dirty_q[index_i][victim_way_o];

endmodule

`default_nettype wire

// ==== dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    // line geometry
    localparam int unsigned WORDS_PER_LINE = 8;
    localparam int unsigned OFFSET_W       = 5;
    localparam int unsigned LINE_NUM_W     = 27;                       // addr[31:5]
    localparam int unsigned WORD_SEL_W     = $clog2(WORDS_PER_LINE);

    // request op encoding
    localparam logic OP_READ  = 1'b0;
    localparam logic OP_WRITE = 1'b1;

    typedef logic [31:0] word_t;

    // word 0 sits in the low bits
    typedef word_t [WORDS_PER_LINE-1:0] line_t;

    typedef struct packed {
        logic                  valid;
        logic [LINE_NUM_W-1:0] num;     // full line number, independent of set count
    } tagv_t;

    typedef struct packed {
        logic        op;                // read 0, write 1
        logic        uncached;
        logic [31:0] addr;
        logic [3:0]  wstrb;
        word_t       wdata;
    } cpu_req_t;

endpackage

`default_nettype wire

// ==== dcache_writeback_buf.sv ====
`default_nettype none

module dcache_writeback_buf
    import dcache_pkg::*;
#(
    parameter int unsigned INDEX_W = 7
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  load_i,
    input  line_t                 victim_line_i,
    input  logic [LINE_NUM_W-1:0] victim_num_i,
    input  logic                  wr_done_i,
    output logic                  wr_req_o,
    output logic [31:0]           wr_addr_o,
    output line_t                 wr_line_o,
    output logic                  busy_o
);

    typedef struct packed {
        logic [LINE_NUM_W-INDEX_W-1:0] tag;
        logic [INDEX_W-1:0]            index;
    } wb_addr_t;

    wb_addr_t addr_q;
    line_t    line_q;
    logic     pend_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            pend_q <= 1'b0;
        end else if (load_i) begin
            pend_q <= 1'b1;
        end else if (wr_done_i) begin
            pend_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load_i) begin
            addr_q <= victim_num_i;
            line_q <= victim_line_i;
        end
    end

    assign wr_req_o  = pend_q;
    assign busy_o    = pend_q && !wr_done_i;   // refill may follow the done pulse
    assign wr_addr_o = {addr_q.tag, addr_q.index, {OFFSET_W{1'b0}}};
    assign wr_line_o = line_q;

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module tb_dcache -o tb_dcache_sim

./obj_dir/tb_dcache_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0

// ==== tb_dcache.sv ====
`default_nettype none

module tb_dcache
    import dcache_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned INDEX_W  = 7;
    localparam logic [31:0] SEED     = 32'hb1915747;
    localparam int unsigned TIMEOUT  = 200;
    localparam int unsigned N_RANDOM = 1500;

    logic        clk;
    logic        reset;
    logic        req_valid;
    cpu_req_t    req;
    logic        addr_ok;
    logic        data_ok;
    word_t       rdata;
    logic        rd_req;
    logic [31:0] rd_addr;
    logic        ret_valid;
    line_t       ret_line;
    logic        wr_req;
    logic [31:0] wr_addr;
    line_t       wr_line;
    logic        wr_done;
    logic        uc_ren;
    logic        uc_wen;
    logic [31:0] uc_addr;
    word_t       uc_wdata;
    logic [3:0]  uc_strb;
    word_t       uc_rdata;
    logic        uc_rvalid;
    logic        uc_bvalid;

    word_t       model_mem [int unsigned];     // keyed by word address
    word_t       mem_stale [int unsigned];     // memory's value of words still dirty in the cache
    word_t       exp_rdata [$];
    logic [31:0] exp_raddr [$];
    cpu_req_t    uc_exp;                       // last uncached request taken
    logic [31:0] drv_rng;

    dcache #(.INDEX_W(INDEX_W)) dcache_i (
        .clk (clk), .reset (reset),
        .req_valid_i (req_valid), .req_i (req), .addr_ok_o (addr_ok),
        .data_ok_o (data_ok), .rdata_o (rdata),
        .rd_req_o (rd_req), .rd_addr_o (rd_addr), .ret_valid_i (ret_valid),
        .ret_line_i (ret_line),
        .wr_req_o (wr_req), .wr_addr_o (wr_addr), .wr_line_o (wr_line), .wr_done_i (wr_done),
        .uc_ren_o (uc_ren), .uc_wen_o (uc_wen), .uc_addr_o (uc_addr), .uc_wdata_o (uc_wdata),
        .uc_strb_o (uc_strb), .uc_rdata_i (uc_rdata), .uc_rvalid_i (uc_rvalid),
        .uc_bvalid_i (uc_bvalid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t read_model(input logic [31:0] addr);
        int unsigned waddr;
        waddr = addr >> 2;
        if (model_mem.exists(waddr)) begin
            return model_mem[waddr];
        end
        return (waddr * 32'h9e37_79b1) ^ 32'h6a09_e667;    // untouched memory
    endfunction

    function automatic word_t merge_word(input word_t old_w, input word_t new_w,
                                         input logic [3:0] strb);
        word_t w;
        w = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                w[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return w;
    endfunction

    function automatic line_t model_line(input logic [31:0] line_addr);
        line_t l;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            l[w] = read_model(line_addr + 32'(4 * w));
        end
        return l;
    endfunction

    // what memory holds, which lags the model by the dirty words
    function automatic line_t memory_line(input logic [31:0] line_addr);
        line_t       l;
        int unsigned waddr;
        l = model_line(line_addr);
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            waddr = (line_addr >> 2) + w;
            if (mem_stale.exists(waddr)) begin
                l[w] = mem_stale[waddr];
            end
        end
        return l;
    endfunction

    function automatic logic [31:0] cached_addr(input int unsigned tag, input int unsigned set,
                                                input int unsigned word);
        return (32'(tag) << (OFFSET_W + INDEX_W)) | (32'(set) << OFFSET_W) | (32'(word) << 2);
    endfunction

    function automatic cpu_req_t make_req(input logic op, input logic [31:0] addr,
                                          input logic [3:0] strb, input word_t data);
        cpu_req_t r;
        r.op       = op;
        r.uncached = 1'b0;
        r.addr     = addr;
        r.wstrb    = strb;
        r.wdata    = data;
        return r;
    endfunction

    task automatic write_model(input logic [31:0] addr, input word_t data, input logic [3:0] strb);
        model_mem[addr >> 2] = merge_word(read_model(addr), data, strb);
    endtask

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic compare_line(input string name, input line_t exp, input line_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic draw(output logic [31:0] v);
        drv_rng = xorshift(drv_rng);
        v       = drv_rng;
    endtask

    // a few sets, five tags each, so lines keep evicting each other
    task automatic random_req(output cpu_req_t r);
        logic [31:0] a;
        logic [31:0] c;
        int unsigned set;
        draw(a);
        draw(c);
        set        = (c[1:0] == 2'd0) ? 5 : (c[1:0] == 2'd1) ? 6 : 77;
        r.op       = a[0];
        r.uncached = (a[3:1] == 3'd0);
        r.wstrb    = a[7:4];
        draw(r.wdata);
        if (r.uncached) begin
            r.addr = {24'h80_0000, c[7:2], 2'b00};
        end else begin
            r.addr = cached_addr((c[31:16] % 5) + 1, set, 32'(c[4:2]));
        end
    endtask

    task automatic record_accept(input cpu_req_t r);
        if (r.uncached) begin
            uc_exp = r;
        end else if (r.op == OP_WRITE) begin
            if (!mem_stale.exists(r.addr >> 2)) begin
                mem_stale[r.addr >> 2] = read_model(r.addr);
            end
            write_model(r.addr, r.wdata, r.wstrb);
        end
        if (r.op == OP_READ) begin
            exp_rdata.push_back(read_model(r.addr));
            exp_raddr.push_back(r.addr);
        end
    endtask

    // holds the request until addr_ok, starting 1 ns after an edge
    task automatic issue(input cpu_req_t r);
        int unsigned waited;
        logic        taken;
        req_valid = 1'b1;
        req       = r;
        waited    = 0;
        taken     = 1'b0;
        while (!taken) begin
            #2;
            taken = addr_ok;
            @(posedge clk);
            #1;
            waited++;
            if (!taken && waited > TIMEOUT) begin
                stop_on_error($sformatf("timeout: request to %h never accepted", r.addr));
            end
        end
        req_valid = 1'b0;
        record_accept(r);
    endtask

    task automatic check_no_cached_port();
        if (rd_req || wr_req) begin
            stop_on_error("refill or write-back request raised during an uncached access");
        end
    endtask

    initial begin : read_monitor
        logic [31:0] a;
        forever begin
            @(posedge clk);
            #3;
            if (!reset && data_ok) begin
                if (exp_rdata.size() == 0) begin
                    stop_on_error("data_ok pulsed with no read outstanding");
                end else begin
                    a = exp_raddr.pop_front();
                    compare_word($sformatf("read %h", a), exp_rdata.pop_front(), rdata);
                end
            end
        end
    end

    initial begin : refill_port
        logic [31:0] rng;
        rng       = SEED ^ 32'h0000_1001;
        ret_valid = 1'b0;
        ret_line  = '0;
        forever begin
            @(posedge clk);
            #3;
            if (rd_req) begin
                compare_word("refill address alignment", 32'h0, 32'(rd_addr[OFFSET_W-1:0]));
                rng = xorshift(rng);
                repeat (rng % 7) @(posedge clk);
                @(posedge clk);
                #1;
                ret_valid = 1'b1;
                ret_line  = memory_line(rd_addr);
                @(posedge clk);
                #1;
                ret_valid = 1'b0;
            end
        end
    end

    initial begin : writeback_port
        logic [31:0] rng;
        rng     = SEED ^ 32'h0000_2002;
        wr_done = 1'b0;
        forever begin
            @(posedge clk);
            #3;
            if (wr_req) begin
                compare_word("write-back address alignment", 32'h0, 32'(wr_addr[OFFSET_W-1:0]));
                compare_line($sformatf("write-back line %h", wr_addr), model_line(wr_addr), wr_line);
                for (int w = 0; w < WORDS_PER_LINE; w++) begin
                    model_mem[(wr_addr >> 2) + w] = wr_line[w];
                    mem_stale.delete((wr_addr >> 2) + w);
                end
                rng = xorshift(rng);
                repeat (rng % 7) @(posedge clk);
                @(posedge clk);
                #1;
                wr_done = 1'b1;
                @(posedge clk);
                #1;
                wr_done = 1'b0;
            end
        end
    end

    initial begin : uncached_port
        logic [31:0] rng;
        logic        is_write;
        rng       = SEED ^ 32'h0000_3003;
        uc_rdata  = '0;
        uc_rvalid = 1'b0;
        uc_bvalid = 1'b0;
        forever begin
            @(posedge clk);
            #3;
            if (uc_ren || uc_wen) begin
                is_write = uc_wen;
                compare_word("uncached address", uc_exp.addr, uc_addr);
                compare_word("uncached op", 32'(uc_exp.op), 32'(is_write));
                if (is_write) begin
                    compare_word("uncached write data", uc_exp.wdata, uc_wdata);
                    compare_word("uncached strobes", 32'(uc_exp.wstrb), 32'(uc_strb));
                end
                check_no_cached_port();
                rng = xorshift(rng);
                repeat (rng % 7) begin
                    @(posedge clk);
                    #3;
                    check_no_cached_port();
                end
                @(posedge clk);
                #1;
                if (is_write) begin
                    write_model(uc_addr, uc_wdata, uc_strb);
                    uc_bvalid = 1'b1;
                end else begin
                    uc_rdata  = read_model(uc_addr);
                    uc_rvalid = 1'b1;
                end
                @(posedge clk);
                #1;
                uc_rvalid = 1'b0;
                uc_bvalid = 1'b0;
            end
        end
    end

    initial begin
        cpu_req_t    r;
        logic [31:0] a;
        int unsigned waited;
        req_valid = 1'b0;
        req       = '0;
        reset     = 1'b1;
        drv_rng   = SEED;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        #2;
        if ({data_ok, rd_req, wr_req, uc_ren, uc_wen} !== 5'b0) begin
            stop_on_error("a request or data_ok output is not low after reset");
        end
        @(posedge clk);
        #1;

        // partial store into a resident line, reads right behind it
        a = cached_addr(2, 9, 3);
        issue(make_req(OP_READ, a, 4'h0, '0));
        issue(make_req(OP_WRITE, a, 4'b0110, 32'hdead_beef));
        issue(make_req(OP_READ, a, 4'h0, '0));
        issue(make_req(OP_READ, a + 32'd4, 4'h0, '0));

        // four lines into one set
        for (int t = 1; t <= 4; t++) begin
            issue(make_req(OP_WRITE, cached_addr(t, 20, 1), 4'hf, 32'(t) * 32'h0101_0101));
        end
        for (int t = 1; t <= 4; t++) begin
            issue(make_req(OP_READ, cached_addr(t, 20, 1), 4'h0, '0));
        end

        for (int n = 0; n < N_RANDOM; n++) begin
            random_req(r);
            issue(r);
        end

        // sweep every word the random phase could touch
        for (int t = 1; t <= 5; t++) begin
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                issue(make_req(OP_READ, cached_addr(t, 5, w), 4'h0, '0));
                issue(make_req(OP_READ, cached_addr(t, 6, w), 4'h0, '0));
                issue(make_req(OP_READ, cached_addr(t, 77, w), 4'h0, '0));
            end
        end

        waited = 0;
        while (exp_rdata.size() != 0 && waited < TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (exp_rdata.size() == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            stop_on_error("timeout: reads still waiting for data_ok at the end of the run");
        end
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
dcache_pkg.sv
cache_ram.sv
dcache_lru_dirty.sv
dcache_line_merge.sv
dcache_writeback_buf.sv
dcache_ctrl.sv
dcache.sv
tb_dcache.sv
